//--- vlog.f
+incdir+sim
common/basicOpPkg.sv
design/scratchMemory.sv
basicOps/satArith16.sv
basicOps/satArith32.sv
basicOps/shiftLeftSeq.sv
basicOps/normalizer.sv
design/lspMathPipe.sv
sim/lspMathPipeTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the lspMathPipe testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module lspMathPipeTb -f vlog.f
./obj_dir/VlspMathPipeTb

//--- sim/basicOpModel.svh
`ifndef BASIC_OP_MODEL_SVH
`define BASIC_OP_MODEL_SVH

//////////////////////////////
// Saturation helpers
//////////////////////////////

function automatic basicOpPkg::word16 sat16(input longint v);
	if (v > 32767)
		return 16'sh7FFF;
	if (v < -32768)
		return 16'sh8000;
	return v[15:0];
endfunction

// Flag reports whether the value had to be clipped
function automatic basicOpPkg::word32 sat32(input longint v, output logic clipped);
	clipped = (v > 64'sd2147483647) || (v < -64'sd2147483648);
	if (v > 64'sd2147483647)
		return 32'sh7FFF_FFFF;
	if (v < -64'sd2147483648)
		return 32'sh8000_0000;
	return v[31:0];
endfunction

// Doubling loop that stops at the first step that would cross the sign
function automatic basicOpPkg::word32 shlSat(input basicOpPkg::word32 v, input int k);
	basicOpPkg::word32 r;
	int i;
	r = v;
	for (i = 0; i < k && i < 32; i++)
	begin
		if (r > 32'sh3FFF_FFFF)
			return 32'sh7FFF_FFFF;
		if (r < 32'shC000_0000)
			return 32'sh8000_0000;
		r = r * 2;
	end
	return r;
endfunction

//////////////////////////////
// 16-bit operators
//////////////////////////////

function automatic basicOpPkg::word16 add16(input basicOpPkg::word16 a, input basicOpPkg::word16 b);
	return sat16(longint'(a) + longint'(b));
endfunction

function automatic basicOpPkg::word16 sub16(input basicOpPkg::word16 a, input basicOpPkg::word16 b);
	return sat16(longint'(a) - longint'(b));
endfunction

function automatic basicOpPkg::word16 mult16(input basicOpPkg::word16 a, input basicOpPkg::word16 b);
	return sat16((longint'(a) * longint'(b)) >>> 15);
endfunction

function automatic basicOpPkg::word16 shr16(input basicOpPkg::word16 v, input basicOpPkg::word16 n);
	longint wide;
	int k;
	if (n >= 0)
	begin
		k = (n > 15) ? 15 : n;
		return v >>> k;
	end
	// Negative count, shift left and clip
	k = (n < -16) ? 16 : -n;
	wide = longint'(v) <<< k;
	return sat16(wide);
endfunction

//////////////////////////////
// 32-bit operators
//////////////////////////////

function automatic basicOpPkg::word32 lMult(input basicOpPkg::word16 a, input basicOpPkg::word16 b,
	output logic ovf);
	basicOpPkg::word32 r;
	r = sat32(2 * longint'(a) * longint'(b), ovf);
	return r;
endfunction

function automatic basicOpPkg::word32 lMac(input basicOpPkg::word32 c, input basicOpPkg::word16 a,
	input basicOpPkg::word16 b, output logic ovf);
	basicOpPkg::word32 p;
	basicOpPkg::word32 r;
	logic pOvf;
	logic sOvf;
	p = lMult(a, b, pOvf);
	r = sat32(longint'(c) + longint'(p), sOvf);
	ovf = pOvf | sOvf;
	return r;
endfunction

function automatic basicOpPkg::word32 lMsu(input basicOpPkg::word32 c, input basicOpPkg::word16 a,
	input basicOpPkg::word16 b, output logic ovf);
	basicOpPkg::word32 p;
	basicOpPkg::word32 r;
	logic pOvf;
	logic sOvf;
	p = lMult(a, b, pOvf);
	r = sat32(longint'(c) - longint'(p), sOvf);
	ovf = pOvf | sOvf;
	return r;
endfunction

function automatic basicOpPkg::word32 lAdd(input basicOpPkg::word32 a, input basicOpPkg::word32 b);
	logic unused;
	return sat32(longint'(a) + longint'(b), unused);
endfunction

function automatic basicOpPkg::word32 lSub(input basicOpPkg::word32 a, input basicOpPkg::word32 b);
	logic unused;
	return sat32(longint'(a) - longint'(b), unused);
endfunction

function automatic basicOpPkg::word32 lShr(input basicOpPkg::word32 v, input basicOpPkg::word16 n);
	int k;
	if (n < 0)
		return shlSat(v, -n);
	k = (n > 31) ? 31 : n;
	return v >>> k;
endfunction

function automatic basicOpPkg::word32 shl32(input basicOpPkg::word32 v, input basicOpPkg::word16 n);
	int k;
	if (n > 0)
		return shlSat(v, n);
	k = (n < -31) ? 31 : -n;
	return v >>> k;
endfunction

// Zero and minus one both report 15
function automatic basicOpPkg::word16 norm16(input basicOpPkg::word16 v);
	basicOpPkg::word16 r;
	int count;
	if (v == 0 || v == -1)
		return 16'sd15;
	r = (v < 0) ? ~v : v;
	count = 0;
	while (r < 16'sh4000)
	begin
		r = r <<< 1;
		count++;
	end
	return 16'(count);
endfunction

`endif

//--- sim/lspMathPipeTb.sv
`timescale 1ns/1ps

module lspMathPipeTb;

	localparam int addrWidth = 11;

	`include "basicOpModel.svh"

	logic clk;
	logic arstN;
	logic lspMuxSel;
	logic [addrWidth-1:0] testReadRequested, testWriteRequested;
	logic [addrWidth-1:0] lspReadRequested, lspWriteRequested;
	basicOpPkg::word32 testLspOut, lspOut, lspIn;
	logic testLspWrite, lspWrite;
	basicOpPkg::word16 L_multOutA, L_multOutB, L_macOutA, L_macOutB, L_msuOutA, L_msuOutB;
	basicOpPkg::word32 L_macOutC, L_msuOutC, L_subOutA, L_subOutB, L_addOutA, L_addOutB;
	basicOpPkg::word32 L_shrOutVar1;
	basicOpPkg::word16 L_shrOutNumShift;
	basicOpPkg::word32 L_multIn, L_macIn, L_msuIn, L_subIn, L_addIn, L_shrIn;
	logic L_multOverflow, L_macOverflow, L_msuOverflow;
	basicOpPkg::word16 addOutA, addOutB, subOutA, subOutB, multOutA, multOutB;
	basicOpPkg::word16 shrOutVar1, shrOutVar2;
	basicOpPkg::word16 addIn, subIn, multIn, shrIn;
	logic L_shlReady, L_shlDone, norm_sReady, norm_sDone;
	basicOpPkg::word32 L_shlVar1Out, L_shlIn;
	basicOpPkg::word16 L_shlNumShiftOut, norm_sOut, norm_sIn;
	integer seed;

	basicOpPkg::word16 corner16 [0:4] = '{16'sh7FFF, 16'sh8000, 16'sh0000, -16'sd1, 16'sd1};
	basicOpPkg::word32 corner32 [0:4] = '{32'sh7FFF_FFFF, 32'sh8000_0000, 32'sh0, -32'sd1, 32'sd1};
	basicOpPkg::word16 shiftCorner [0:7] = '{16'sd0, -16'sd1, 16'sd1, 16'sd15, -16'sd16,
		16'sd31, -16'sd33, 16'sd40};

	lspMathPipe #(.addrWidth(addrWidth)) lspMathPipe_inst (.*);

	initial
		clk = 1'b0;

	always
		#20 clk = ~clk;

	//////////////////////////////
	// Checking and waiting
	//////////////////////////////

	task automatic stopRun();
		$display("Something failed");
		$fatal(1, "Stopped at the first failing check");
	endtask

	task automatic reportMismatch(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		$display("error at %0t ns: %s returned %0h, expected %0h", $time, what, got, expected);
		stopRun();
	endtask

	task automatic expectEqual(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else
			reportMismatch(what, got, expected);
	endtask

	// Returns on the falling edge where done is seen high
	task automatic waitDone(input bit normUnit);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!(normUnit ? norm_sDone : L_shlDone))
		begin
			if (waited == 64)
			begin
				$display("Timed out after 64 cycles waiting for %s done",
					normUnit ? "norm_s" : "L_shl");
				stopRun();
			end
			waited++;
			@(negedge clk);
		end
	endtask

	//////////////////////////////
	// Scratch memory
	//////////////////////////////

	task automatic writeWord(input bit viaTest, input logic [addrWidth-1:0] addr,
		input basicOpPkg::word32 data);
		@(posedge clk);
		if (viaTest)
		begin
			testWriteRequested <= addr;
			testLspOut <= data;
			testLspWrite <= 1'b1;
		end
		else
		begin
			lspWriteRequested <= addr;
			lspOut <= data;
			lspWrite <= 1'b1;
		end
		@(posedge clk);
		testLspWrite <= 1'b0;
		lspWrite <= 1'b0;
	endtask

	task automatic readWord(input bit viaTest, input logic [addrWidth-1:0] addr,
		input basicOpPkg::word32 expected, input string what);
		@(posedge clk);
		if (viaTest)
			testReadRequested <= addr;
		else
			lspReadRequested <= addr;
		@(posedge clk);
		@(negedge clk);
		expectEqual(what, lspIn, expected);
	endtask

	task automatic memoryTest();
		logic [addrWidth-1:0] addr [0:5];
		basicOpPkg::word32 stored [0:5];
		int i;
		for (i = 0; i < 6; i++)
		begin
			addr[i] = addrWidth'(i * 341 + 7);
			stored[i] = $random(seed);
		end
		@(posedge clk);
		lspMuxSel <= 1'b1;
		for (i = 0; i < 6; i++)
			writeWord(1'b1, addr[i], stored[i]);
		for (i = 0; i < 6; i++)
			readWord(1'b1, addr[i], stored[i], "test port readback");
		// Functional side has no effect while the test port owns the memory
		for (i = 0; i < 6; i++)
			writeWord(1'b0, addr[i], ~stored[i]);
		for (i = 0; i < 6; i++)
			readWord(1'b1, addr[i], stored[i], "blocked functional write");
		@(posedge clk);
		lspMuxSel <= 1'b0;
		// Same address written and read on one edge
		@(posedge clk);
		lspWriteRequested <= addr[0];
		lspOut <= ~stored[0];
		lspWrite <= 1'b1;
		lspReadRequested <= addr[0];
		@(posedge clk);
		lspWrite <= 1'b0;
		@(negedge clk);
		expectEqual("read during write", lspIn, stored[0]);
		stored[0] = ~stored[0];
		for (i = 1; i < 6; i++)
		begin
			stored[i] = $random(seed);
			writeWord(1'b0, addr[i], stored[i]);
		end
		for (i = 0; i < 6; i++)
			readWord(1'b0, addr[i], stored[i], "functional readback");
	endtask

	//////////////////////////////
	// Combinational operators
	//////////////////////////////

	task automatic check16(input basicOpPkg::word16 a, input basicOpPkg::word16 b,
		input basicOpPkg::word16 n);
		@(posedge clk);
		addOutA <= a;
		addOutB <= b;
		subOutA <= a;
		subOutB <= b;
		multOutA <= a;
		multOutB <= b;
		shrOutVar1 <= a;
		shrOutVar2 <= n;
		@(negedge clk);
		expectEqual("add", addIn, add16(a, b));
		expectEqual("sub", subIn, sub16(a, b));
		expectEqual("mult", multIn, mult16(a, b));
		expectEqual("shr", shrIn, shr16(a, n));
	endtask

	task automatic check32(input basicOpPkg::word16 a, input basicOpPkg::word16 b,
		input basicOpPkg::word32 c, input basicOpPkg::word32 d, input basicOpPkg::word16 n);
		basicOpPkg::word32 expected;
		logic flag;
		@(posedge clk);
		L_multOutA <= a;
		L_multOutB <= b;
		L_macOutA <= a;
		L_macOutB <= b;
		L_macOutC <= c;
		L_msuOutA <= a;
		L_msuOutB <= b;
		L_msuOutC <= c;
		L_addOutA <= c;
		L_addOutB <= d;
		L_subOutA <= c;
		L_subOutB <= d;
		L_shrOutVar1 <= c;
		L_shrOutNumShift <= n;
		@(negedge clk);
		expected = lMult(a, b, flag);
		expectEqual("L_mult", L_multIn, expected);
		expectEqual("L_mult overflow", L_multOverflow, flag);
		expected = lMac(c, a, b, flag);
		expectEqual("L_mac", L_macIn, expected);
		expectEqual("L_mac overflow", L_macOverflow, flag);
		expected = lMsu(c, a, b, flag);
		expectEqual("L_msu", L_msuIn, expected);
		expectEqual("L_msu overflow", L_msuOverflow, flag);
		expectEqual("L_add", L_addIn, lAdd(c, d));
		expectEqual("L_sub", L_subIn, lSub(c, d));
		expectEqual("L_shr", L_shrIn, lShr(c, n));
	endtask

	task automatic arithTest();
		int i;
		int j;
		for (i = 0; i < 5; i++)
			for (j = 0; j < 5; j++)
			begin
				check16(corner16[i], corner16[j], shiftCorner[(i * 5 + j) % 8]);
				check32(corner16[i], corner16[j], corner32[i], corner32[j],
					shiftCorner[(i * 5 + j) % 8]);
			end
		for (i = 0; i < 200; i++)
		begin
			check16(16'($random(seed)), 16'($random(seed)), 16'($random(seed) % 40));
			check32(16'($random(seed)), 16'($random(seed)), $random(seed), $random(seed),
				16'($random(seed) % 40));
		end
	endtask

	//////////////////////////////
	// Multi-cycle units
	//////////////////////////////

	task automatic runShl(input basicOpPkg::word32 v, input basicOpPkg::word16 n);
		basicOpPkg::word32 expected;
		expected = shl32(v, n);
		@(posedge clk);
		L_shlReady <= 1'b1;
		L_shlVar1Out <= v;
		L_shlNumShiftOut <= n;
		@(posedge clk);
		L_shlReady <= 1'b0;
		waitDone(1'b0);
		expectEqual("L_shl", L_shlIn, expected);
		@(negedge clk);
		expectEqual("L_shl done pulse", L_shlDone, 1'b0);
		// New operands without ready must not disturb the result
		@(posedge clk);
		L_shlVar1Out <= ~v;
		L_shlNumShiftOut <= -n;
		repeat (3) @(negedge clk);
		expectEqual("L_shl held result", L_shlIn, expected);
	endtask

	task automatic runNorm(input basicOpPkg::word16 v);
		basicOpPkg::word16 expected;
		expected = norm16(v);
		@(posedge clk);
		norm_sReady <= 1'b1;
		norm_sOut <= v;
		@(posedge clk);
		norm_sReady <= 1'b0;
		waitDone(1'b1);
		expectEqual("norm_s", norm_sIn, expected);
		@(negedge clk);
		expectEqual("norm_s done pulse", norm_sDone, 1'b0);
	endtask

	task automatic multiCycleTest();
		int i;
		int j;
		for (i = 0; i < 5; i++)
			for (j = 0; j < 8; j++)
				runShl(corner32[i], shiftCorner[j]);
		runShl(32'sh4000_0000, 16'sd1);
		runShl(32'shC000_0000, 16'sd1);
		runShl(32'shBFFF_FFFF, 16'sd1);
		runShl(32'sd1, 16'sd31);
		for (i = 0; i < 40; i++)
			runShl($random(seed), 16'($random(seed) % 41));

		runNorm(16'sh0000);
		runNorm(-16'sd1);
		runNorm(16'sh4000);
		runNorm(16'sh8000);
		for (i = 0; i < 5; i++)
			runNorm(corner16[i]);
		for (i = 0; i < 60; i++)
			runNorm(16'($random(seed)));

		// Second ready lands while the unit is still shifting
		@(posedge clk);
		norm_sReady <= 1'b1;
		norm_sOut <= 16'sh0001;
		@(posedge clk);
		norm_sReady <= 1'b0;
		repeat (2) @(posedge clk);
		norm_sReady <= 1'b1;
		norm_sOut <= 16'sh4000;
		@(posedge clk);
		norm_sReady <= 1'b0;
		waitDone(1'b1);
		expectEqual("norm_s with ignored ready", norm_sIn, norm16(16'sh0001));
		repeat (20)
		begin
			@(negedge clk);
			expectEqual("norm_s done after ignored ready", norm_sDone, 1'b0);
		end
	endtask

	task automatic checkResetState();
		@(negedge clk);
		expectEqual("L_shlDone after reset", L_shlDone, 1'b0);
		expectEqual("norm_sDone after reset", norm_sDone, 1'b0);
		expectEqual("L_shlIn after reset", L_shlIn, 32'h0);
		expectEqual("norm_sIn after reset", norm_sIn, 32'h0);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin : mainSequence
		seed = 18535;
		arstN <= 1'b0;
		lspMuxSel <= 1'b0;
		testReadRequested <= '0;
		testWriteRequested <= '0;
		testLspOut <= '0;
		testLspWrite <= 1'b0;
		lspReadRequested <= '0;
		lspWriteRequested <= '0;
		lspOut <= '0;
		lspWrite <= 1'b0;
		L_multOutA <= '0;
		L_multOutB <= '0;
		L_macOutA <= '0;
		L_macOutB <= '0;
		L_macOutC <= '0;
		L_msuOutA <= '0;
		L_msuOutB <= '0;
		L_msuOutC <= '0;
		L_subOutA <= '0;
		L_subOutB <= '0;
		L_addOutA <= '0;
		L_addOutB <= '0;
		L_shrOutVar1 <= '0;
		L_shrOutNumShift <= '0;
		addOutA <= '0;
		addOutB <= '0;
		subOutA <= '0;
		subOutB <= '0;
		multOutA <= '0;
		multOutB <= '0;
		shrOutVar1 <= '0;
		shrOutVar2 <= '0;
		L_shlReady <= 1'b0;
		L_shlVar1Out <= '0;
		L_shlNumShiftOut <= '0;
		norm_sReady <= 1'b0;
		norm_sOut <= '0;

		repeat (8) @(posedge clk);
		arstN <= 1'b1;
		checkResetState();
		memoryTest();
		arithTest();
		multiCycleTest();

		$display("Everything OK");
		$finish;
	end

endmodule

//--- design/lspMathPipe.sv
`timescale 1ns/1ps

module lspMathPipe
#(
	parameter int addrWidth = 11
)
(
	input logic clk,
	input logic arstN,

	// Scratch memory, test and functional sides
	input logic lspMuxSel,
	input logic [addrWidth-1:0] testReadRequested,
	input logic [addrWidth-1:0] testWriteRequested,
	input basicOpPkg::word32 testLspOut,
	input logic testLspWrite,
	input logic [addrWidth-1:0] lspReadRequested,
	input logic [addrWidth-1:0] lspWriteRequested,
	input basicOpPkg::word32 lspOut,
	input logic lspWrite,
	output basicOpPkg::word32 lspIn,

	// 32-bit group
	input basicOpPkg::word16 L_multOutA, L_multOutB,
	input basicOpPkg::word16 L_macOutA, L_macOutB,
	input basicOpPkg::word32 L_macOutC,
	input basicOpPkg::word16 L_msuOutA, L_msuOutB,
	input basicOpPkg::word32 L_msuOutC,
	input basicOpPkg::word32 L_subOutA, L_subOutB,
	input basicOpPkg::word32 L_addOutA, L_addOutB,
	input basicOpPkg::word32 L_shrOutVar1,
	input basicOpPkg::word16 L_shrOutNumShift,
	output basicOpPkg::word32 L_multIn, L_macIn, L_msuIn,
	output logic L_multOverflow, L_macOverflow, L_msuOverflow,
	output basicOpPkg::word32 L_subIn, L_addIn, L_shrIn,

	// 16-bit group
	input basicOpPkg::word16 addOutA, addOutB,
	input basicOpPkg::word16 subOutA, subOutB,
	input basicOpPkg::word16 multOutA, multOutB,
	input basicOpPkg::word16 shrOutVar1, shrOutVar2,
	output basicOpPkg::word16 addIn, subIn, multIn, shrIn,

	// Multi-cycle units
	input logic L_shlReady,
	input basicOpPkg::word32 L_shlVar1Out,
	input basicOpPkg::word16 L_shlNumShiftOut,
	output basicOpPkg::word32 L_shlIn,
	output logic L_shlDone,
	input logic norm_sReady,
	input basicOpPkg::word16 norm_sOut,
	output basicOpPkg::word16 norm_sIn,
	output logic norm_sDone
);

	logic [addrWidth-1:0] memReadAddr;
	logic [addrWidth-1:0] memWriteAddr;
	basicOpPkg::word32 memWriteData;
	logic memWriteEnable;

	//////////////////////////////
	// Memory source selector
	//////////////////////////////

	always_comb
	begin
		if (lspMuxSel)
		begin
			memReadAddr = testReadRequested;
			memWriteAddr = testWriteRequested;
			memWriteData = testLspOut;
			memWriteEnable = testLspWrite;
		end
		else
		begin
			memReadAddr = lspReadRequested;
			memWriteAddr = lspWriteRequested;
			memWriteData = lspOut;
			memWriteEnable = lspWrite;
		end
	end

	scratchMemory #(.addrWidth(addrWidth)) scratch
	(
		.clk(clk),
		.writeAddr(memWriteAddr), .writeData(memWriteData), .writeEnable(memWriteEnable),
		.readAddr(memReadAddr), .readData(lspIn)
	);

	//////////////////////////////
	// Operators
	//////////////////////////////

	satArith16 arith16
	(
		.addA(addOutA), .addB(addOutB), .addSum(addIn),
		.subA(subOutA), .subB(subOutB), .subDiff(subIn),
		.multA(multOutA), .multB(multOutB), .multProduct(multIn),
		.shrVar1(shrOutVar1), .shrVar2(shrOutVar2), .shrResult(shrIn)
	);

	satArith32 arith32
	(
		.lMultA(L_multOutA), .lMultB(L_multOutB),
		.lMultProduct(L_multIn), .lMultOverflow(L_multOverflow),
		.lMacA(L_macOutA), .lMacB(L_macOutB), .lMacC(L_macOutC),
		.lMacOut(L_macIn), .lMacOverflow(L_macOverflow),
		.lMsuA(L_msuOutA), .lMsuB(L_msuOutB), .lMsuC(L_msuOutC),
		.lMsuOut(L_msuIn), .lMsuOverflow(L_msuOverflow),
		.lAddA(L_addOutA), .lAddB(L_addOutB), .lAddSum(L_addIn),
		.lSubA(L_subOutA), .lSubB(L_subOutB), .lSubDiff(L_subIn),
		.lShrVar1(L_shrOutVar1), .lShrNumShift(L_shrOutNumShift), .lShrOut(L_shrIn)
	);

	shiftLeftSeq lShlUnit
	(
		.clk(clk), .arstN(arstN), .ready(L_shlReady),
		.var1(L_shlVar1Out), .numShift(L_shlNumShiftOut),
		.out(L_shlIn), .done(L_shlDone)
	);

	normalizer normUnit
	(
		.clk(clk), .arstN(arstN), .ready(norm_sReady),
		.var1(norm_sOut), .norm(norm_sIn), .done(norm_sDone)
	);

endmodule

//--- basicOps/normalizer.sv
`timescale 1ns/1ps

module normalizer
(
	input logic clk,
	input logic arstN,
	input logic ready,
	input basicOpPkg::word16 var1,
	output basicOpPkg::word16 norm,
	output logic done
);

	basicOpPkg::seqState state;
	basicOpPkg::word16 work;
	logic [3:0] shiftCount;
	logic isTrivial;
	logic isNormal;

	// 0 and -1 never normalize
	always_comb
	begin
		isTrivial = (work == 16'sd0) || (&work);
		isNormal = work[15] != work[14];
	end

	always_ff @(posedge clk)
	begin
		if (state == basicOpPkg::idle && ready)
		begin
			work <= var1;
			shiftCount <= 4'd0;
		end
		else if (state == basicOpPkg::busy && !isTrivial && !isNormal)
		begin
			work <= work <<< 1;
			shiftCount <= shiftCount + 4'd1;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= basicOpPkg::idle;
			norm <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				basicOpPkg::idle:
				begin
					if (ready)
						state <= basicOpPkg::busy;
				end
				basicOpPkg::busy:
				begin
					if (isTrivial)
					begin
						norm <= 16'sd15;
						done <= 1'b1;
						state <= basicOpPkg::idle;
					end
					else if (isNormal)
					begin
						norm <= {12'd0, shiftCount};
						done <= 1'b1;
						state <= basicOpPkg::idle;
					end
				end
			endcase
		end
	end

endmodule

//--- basicOps/shiftLeftSeq.sv
`timescale 1ns/1ps

module shiftLeftSeq
(
	input logic clk,
	input logic arstN,
	input logic ready,
	input basicOpPkg::word32 var1,
	input basicOpPkg::word16 numShift,
	output basicOpPkg::word32 out,
	output logic done
);

	basicOpPkg::seqState state;
	basicOpPkg::word32 work;
	basicOpPkg::word16 stepsLeft;
	logic signed [16:0] rightWide;
	logic [4:0] rightCount;

	// Magnitude of a count of zero or less
	always_comb
	begin
		rightWide = 17'sd0 - stepsLeft;
		rightCount = (rightWide > 31) ? 5'd31 : rightWide[4:0];
	end

	// Working word, one bit per cycle
	always_ff @(posedge clk)
	begin
		if (state == basicOpPkg::idle && ready)
		begin
			work <= var1;
			stepsLeft <= numShift;
		end
		else if (state == basicOpPkg::busy && stepsLeft > 0)
		begin
			stepsLeft <= stepsLeft - 16'sd1;
			// Sign would flip, so clamp and hold
			if (work[31] != work[30])
				work <= work[31] ? basicOpPkg::min32 : basicOpPkg::max32;
			else
				work <= work <<< 1;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= basicOpPkg::idle;
			out <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				basicOpPkg::idle:
				begin
					if (ready)
						state <= basicOpPkg::busy;
				end
				basicOpPkg::busy:
				begin
					if (stepsLeft <= 0)
					begin
						out <= work >>> rightCount;
						done <= 1'b1;
						state <= basicOpPkg::idle;
					end
				end
			endcase
		end
	end

endmodule

//--- basicOps/satArith32.sv
`timescale 1ns/1ps

module satArith32
(
	input basicOpPkg::word16 lMultA,
	input basicOpPkg::word16 lMultB,
	output basicOpPkg::word32 lMultProduct,
	output logic lMultOverflow,
	input basicOpPkg::word16 lMacA,
	input basicOpPkg::word16 lMacB,
	input basicOpPkg::word32 lMacC,
	output basicOpPkg::word32 lMacOut,
	output logic lMacOverflow,
	input basicOpPkg::word16 lMsuA,
	input basicOpPkg::word16 lMsuB,
	input basicOpPkg::word32 lMsuC,
	output basicOpPkg::word32 lMsuOut,
	output logic lMsuOverflow,
	input basicOpPkg::word32 lAddA,
	input basicOpPkg::word32 lAddB,
	output basicOpPkg::word32 lAddSum,
	input basicOpPkg::word32 lSubA,
	input basicOpPkg::word32 lSubB,
	output basicOpPkg::word32 lSubDiff,
	input basicOpPkg::word32 lShrVar1,
	input basicOpPkg::word16 lShrNumShift,
	output basicOpPkg::word32 lShrOut
);

	//////////////////////////////
	// Shared helpers
	//////////////////////////////

	// Doubled product with the overflow flag on top
	function automatic logic [32:0] lMultCalc(input basicOpPkg::word16 a, input basicOpPkg::word16 b);
		basicOpPkg::word32 product;
		product = a * b;
		if (product == 32'sh4000_0000)
			return {1'b1, basicOpPkg::max32};
		return {1'b0, product <<< 1};
	endfunction

	function automatic basicOpPkg::word32 clip33(input logic signed [32:0] wide);
		if (wide[32] != wide[31])
			return wide[32] ? basicOpPkg::min32 : basicOpPkg::max32;
		return wide[31:0];
	endfunction

	logic [32:0] multResult;
	logic [32:0] macProduct;
	logic [32:0] msuProduct;
	logic signed [32:0] macWide;
	logic signed [32:0] msuWide;
	logic signed [32:0] addWide;
	logic signed [32:0] subWide;
	logic signed [16:0] shrNegCount;
	logic [5:0] shrLeftCount;
	logic [4:0] shrRightCount;
	logic signed [63:0] shrLeftWide;
	logic shrLeftFits;

	always_comb
	begin
		multResult = lMultCalc(lMultA, lMultB);
		lMultProduct = multResult[31:0];
		lMultOverflow = multResult[32];

		// Accumulate, flag either stage saturating
		macProduct = lMultCalc(lMacA, lMacB);
		macWide = lMacC + $signed(macProduct[31:0]);
		lMacOut = clip33(macWide);
		lMacOverflow = macProduct[32] | (macWide[32] != macWide[31]);

		msuProduct = lMultCalc(lMsuA, lMsuB);
		msuWide = lMsuC - $signed(msuProduct[31:0]);
		lMsuOut = clip33(msuWide);
		lMsuOverflow = msuProduct[32] | (msuWide[32] != msuWide[31]);

		addWide = lAddA + lAddB;
		subWide = lSubA - lSubB;
		lAddSum = clip33(addWide);
		lSubDiff = clip33(subWide);

		// L_shr, negative count shifts left capped at 32
		shrNegCount = 17'sd0 - lShrNumShift;
		shrLeftCount = (shrNegCount > 32) ? 6'd32 : shrNegCount[5:0];
		shrLeftWide = lShrVar1;
		shrLeftWide = shrLeftWide <<< shrLeftCount;
		shrLeftFits = (&shrLeftWide[63:31]) | ~(|shrLeftWide[63:31]);
		shrRightCount = (lShrNumShift > 31) ? 5'd31 : lShrNumShift[4:0];

		if (lShrNumShift < 0)
			lShrOut = shrLeftFits ? shrLeftWide[31:0]
				: (lShrVar1[31] ? basicOpPkg::min32 : basicOpPkg::max32);
		else
			lShrOut = lShrVar1 >>> shrRightCount;
	end

endmodule

//--- basicOps/satArith16.sv
`timescale 1ns/1ps

module satArith16
(
	input basicOpPkg::word16 addA,
	input basicOpPkg::word16 addB,
	output basicOpPkg::word16 addSum,
	input basicOpPkg::word16 subA,
	input basicOpPkg::word16 subB,
	output basicOpPkg::word16 subDiff,
	input basicOpPkg::word16 multA,
	input basicOpPkg::word16 multB,
	output basicOpPkg::word16 multProduct,
	input basicOpPkg::word16 shrVar1,
	input basicOpPkg::word16 shrVar2,
	output basicOpPkg::word16 shrResult
);

	logic signed [16:0] addWide;
	logic signed [16:0] subWide;
	logic signed [31:0] multWide;
	logic signed [16:0] multScaled;
	logic signed [16:0] shrNegCount;
	logic [4:0] shrLeftCount;
	logic [3:0] shrRightCount;
	logic signed [31:0] shrLeftWide;
	logic shrLeftFits;

	// Clip a 17-bit result into 16 bits
	function automatic basicOpPkg::word16 clip17(input logic signed [16:0] wide);
		if (wide[16] != wide[15])
			return wide[16] ? basicOpPkg::min16 : basicOpPkg::max16;
		return wide[15:0];
	endfunction

	always_comb
	begin
		addWide = addA + addB;
		subWide = subA - subB;
		addSum = clip17(addWide);
		subDiff = clip17(subWide);

		// Q15 product, only -1 * -1 lands outside the range
		multWide = multA * multB;
		multScaled = multWide[31:15];
		multProduct = clip17(multScaled);

		// Negative count means shl, capped at 16 positions
		shrNegCount = 17'sd0 - shrVar2;
		shrLeftCount = (shrNegCount > 16) ? 5'd16 : shrNegCount[4:0];
		shrLeftWide = shrVar1;
		shrLeftWide = shrLeftWide <<< shrLeftCount;
		shrLeftFits = (&shrLeftWide[31:15]) | ~(|shrLeftWide[31:15]);

		// 15 or more leaves only sign bits
		shrRightCount = (shrVar2 > 15) ? 4'd15 : shrVar2[3:0];

		if (shrVar2 < 0)
		begin
			if (shrLeftFits)
				shrResult = shrLeftWide[15:0];
			else
				shrResult = shrVar1[15] ? basicOpPkg::min16 : basicOpPkg::max16;
		end
		else
			shrResult = shrVar1 >>> shrRightCount;
	end

endmodule

//--- design/scratchMemory.sv
`timescale 1ns/1ps

module scratchMemory
#(
	parameter int addrWidth = 11
)
(
	input logic clk,
	input logic [addrWidth-1:0] writeAddr,
	input basicOpPkg::word32 writeData,
	input logic writeEnable,
	input logic [addrWidth-1:0] readAddr,
	output basicOpPkg::word32 readData
);

	// LSP scratch words
	basicOpPkg::word32 mem [0:(1 << addrWidth) - 1];

	// Write port
	always_ff @(posedge clk)
	begin
		if (writeEnable)
			mem[writeAddr] <= writeData;
	end

	// Registered read, same-address write gives the old word
	always_ff @(posedge clk)
	begin
		readData <= mem[readAddr];
	end

endmodule

//--- common/basicOpPkg.sv
package basicOpPkg;

	//////////////////////////////
	// Fixed-point word types
	//////////////////////////////

	// Q15 style operand word
	typedef logic signed [15:0] word16;

	// Q31 style accumulator word, also the scratch memory data
	typedef logic signed [31:0] word32;

	//////////////////////////////
	// Saturation limits
	//////////////////////////////

	localparam word16 max16 = 16'sh7FFF;
	localparam word16 min16 = 16'sh8000;

	localparam word32 max32 = 32'sh7FFF_FFFF;
	localparam word32 min32 = 32'sh8000_0000;

	//////////////////////////////
	// Multi-cycle unit sequencing
	//////////////////////////////

	// Waiting for ready, or stepping one bit per cycle
	typedef enum logic {idle, busy} seqState;

endpackage
